//--- ringMmio.f
+incdir+source
source/ringMmioPkg.sv
source/ringOpDecode.sv
source/mmioRequestEngine.sv
source/ringSlotMerge.sv
source/mmioRegisterBlock.sv
source/ringMmioNode.sv
sim/clockGen.sv
sim/ringMmioNodeTb.sv

//--- sim/clockGen.sv
/*
 Testbench clock and reset source:
 20 ns clock, reset held high for two rising edges.
 */

`timescale 1ns/100ps

module clockGen (
	output logic clock,
	output logic reset
);

	localparam time HALF_PERIOD = 10;
	localparam int  RESET_CYCLES = 2;

	initial
	begin
		clock = 1'b0;
		forever
			#HALF_PERIOD clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		reset = 1'b0;	// released with the other inputs, 2 ns after the edge
	end

endmodule

//--- sim/ringMmioNodeTb.sv
/*
 Testbench of the ring MMIO node: stimulus for pass-through,
 64/32-bit loads and stores, busy pass-through, back-pressure
 and out-of-window access, with a register mirror as reference,
 a per-cycle ringOut checker and a cycle timeout.
 */

`timescale 1ns/100ps

`include "ringMmio_cfg.svh"

module ringMmioNodeTb;

	localparam int RANDOM_SEED    = 58543;
	localparam int REG_COUNT      = `RM_REG_COUNT;
	localparam int DRAIN_CYCLES   = 8;	// idle gap until the engine is free again
	localparam int FOREIGN_CYCLES = 64;
	localparam int BURST_CYCLES   = 40;
	localparam int END_CYCLES     = 4;
	localparam int TXN_COUNT      = 2 + 7 + 2 + 1 + 22;	// served requests over all tests
	localparam int TXN_CYCLES     = 4 * `RM_WAIT_STATES + 16 + DRAIN_CYCLES;
	localparam int TEST_CYCLES    = 4 + FOREIGN_CYCLES + 1 + BURST_CYCLES + 1
		+ TXN_COUNT * TXN_CYCLES + END_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	// what the output slot should be for the slot driven in
	localparam int KIND_IDLE     = 0;	// idle, a response may take it
	localparam int KIND_PASS     = 1;
	localparam int KIND_TAKE     = 2;	// request consumed
	localparam int KIND_RESP_DUE = 3;	// idle, the response must take it

	logic                 clock;
	logic                 reset;
	ringMmioPkg::ringSlot ringIn;
	ringMmioPkg::ringSlot ringOut;
	int                   slotKind;
	logic [63:0]          mirror [REG_COUNT];
	ringMmioPkg::ringSlot respQueue [$];
	int                   responsesSeen = 0;
	int                   cycleCount = 0;
	string                testName = "reset";

	clockGen i_clockGen (
		.clock (clock),
		.reset (reset)
	);

	ringMmioNode i_ringMmioNode (
		.clock   (clock),
		.reset   (reset),
		.ringIn  (ringIn),
		.ringOut (ringOut)
	);

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual)
			stopWithFailure($sformatf("error %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
	endtask

	function automatic logic [31:0] regAddr(input int index);
		return `RM_WINDOW_BASE + 32'(index * 8);
	endfunction

	// register mirror, returns the data the device answers with
	function automatic logic [63:0] referenceAccess(input logic [7:0] opCode,
		input logic [31:0] addr, input logic [63:0] data);
		logic [31:0] offset;
		int          index;
		logic [63:0] result;
		offset = addr - `RM_WINDOW_BASE;
		index  = int'(offset >> 3);
		result = '0;
		if (offset < 32'(REG_COUNT * 8))
		begin
			if (opCode == ringMmioPkg::RING_OPM_LDSQ)
				result = mirror[index];
			else if (opCode == ringMmioPkg::RING_OPM_LDSL)
				result = {{32{mirror[index][31]}}, mirror[index][31:0]};
			else if (opCode == ringMmioPkg::RING_OPM_STSQ)
				mirror[index] = data;
			else if (opCode == ringMmioPkg::RING_OPM_STSL)
				mirror[index][31:0] = data[31:0];	// upper half kept
		end
		return result;
	endfunction

	function automatic ringMmioPkg::ringSlot expectedResponse(input ringMmioPkg::ringSlot req);
		ringMmioPkg::ringSlot resp;
		resp.seq  = req.seq;
		resp.opm  = {req.opm[15:8], ringMmioPkg::RING_OPM_OKLD};
		resp.addr = req.addr;
		resp.data = referenceAccess(req.opm[7:0], req.addr, req.data);
		return resp;
	endfunction

	// output slot for anything that is not a response
	function automatic ringMmioPkg::ringSlot referenceSlot(input int kind,
		input ringMmioPkg::ringSlot inSlot);
		if (kind == KIND_TAKE)
			return ringMmioPkg::RING_SLOT_IDLE;
		return inSlot;
	endfunction

	function automatic logic isMmioCode(input logic [7:0] opCode);
		return opCode == ringMmioPkg::RING_OPM_LDSQ || opCode == ringMmioPkg::RING_OPM_LDSL
			|| opCode == ringMmioPkg::RING_OPM_STSQ || opCode == ringMmioPkg::RING_OPM_STSL;
	endfunction

	function automatic ringMmioPkg::ringSlot randomForeign();
		ringMmioPkg::ringSlot slot;
		logic [7:0]           opCode;
		opCode = 8'($urandom);
		while (isMmioCode(opCode) || opCode == ringMmioPkg::RING_OPM_IDLE)
			opCode = 8'($urandom);
		slot.seq  = 16'($urandom);
		slot.opm  = {8'($urandom), opCode};
		slot.addr = $urandom;
		slot.data = {$urandom, $urandom};
		return slot;
	endfunction

	function automatic ringMmioPkg::ringSlot makeRequest(input logic [7:0] opCode,
		input logic [31:0] addr, input logic [63:0] data);
		ringMmioPkg::ringSlot slot;
		slot.seq  = 16'($urandom);
		slot.opm  = {8'($urandom), opCode};	// random flags byte
		slot.addr = addr;
		slot.data = data;
		return slot;
	endfunction

	task automatic driveSlot(input ringMmioPkg::ringSlot slot, input int kind);
		@(posedge clock);
		#2;
		ringIn   = slot;
		slotKind = kind;
	endtask

	task automatic waitForResponse(input int seenBefore);
		while (responsesSeen == seenBefore)
			driveSlot(ringMmioPkg::RING_SLOT_IDLE, KIND_IDLE);
	endtask

	task automatic drainIdle();
		repeat (DRAIN_CYCLES) driveSlot(ringMmioPkg::RING_SLOT_IDLE, KIND_IDLE);
	endtask

	task automatic runRequest(input ringMmioPkg::ringSlot req);
		int seen;
		seen = responsesSeen;
		respQueue.push_back(expectedResponse(req));
		driveSlot(req, KIND_TAKE);
		waitForResponse(seen);
		drainIdle();
	endtask

	task automatic compareResponse();
		ringMmioPkg::ringSlot expected;
		if (respQueue.size() == 0)
			stopWithFailure("a response slot appeared on the ring with no request outstanding");
		else
		begin
			expected = respQueue.pop_front();
			checkValue({testName, " seq"}, expected.seq, ringOut.seq);
			checkValue({testName, " opm"}, expected.opm, ringOut.opm);
			checkValue({testName, " addr"}, expected.addr, ringOut.addr);
			checkValue({testName, " data"}, expected.data, ringOut.data);
			responsesSeen++;
		end
	endtask

	// ringOut checker, one slot per cycle
	initial
	begin
		ringMmioPkg::ringSlot inSlot;
		int                   inKind;
		logic                 inReset;
		forever
		begin
			@(posedge clock);
			inSlot  = ringIn;	// stable since the last drive
			inKind  = slotKind;
			inReset = reset;
			@(negedge clock);
			if (inReset)
				checkValue("reset", ringMmioPkg::RING_SLOT_IDLE, ringOut);
			else if (inKind == KIND_RESP_DUE)
			begin
				checkValue({testName, " response in first idle slot"},
					ringMmioPkg::RING_OPM_OKLD, ringOut.opm[7:0]);
				compareResponse();
			end
			else if (inKind == KIND_IDLE && ringOut.opm[7:0] == ringMmioPkg::RING_OPM_OKLD)
				compareResponse();
			else
				checkValue({testName, " slot"}, referenceSlot(inKind, inSlot), ringOut);
		end
	end

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
			stopWithFailure($sformatf("the run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	initial
	begin
		ringMmioPkg::ringSlot first;
		ringMmioPkg::ringSlot second;
		logic [31:0]          wordSet;
		logic [31:0]          wordClear;
		int                   seen;
		void'($urandom(RANDOM_SEED));
		ringIn   = randomForeign();	// ringOut must stay idle while reset is high
		slotKind = KIND_PASS;
		for (int i = 0; i < REG_COUNT; i++)
			mirror[i] = '0;	// device clears its bank at reset
		wait (reset === 1'b0);

		testName = "pass-through";
		repeat (FOREIGN_CYCLES)
		begin
			if ($urandom_range(0, 3) == 0)
				driveSlot(ringMmioPkg::RING_SLOT_IDLE, KIND_IDLE);
			else
				driveSlot(randomForeign(), KIND_PASS);
		end

		testName = "store64 then load64";
		runRequest(makeRequest(ringMmioPkg::RING_OPM_STSQ, regAddr(5), {$urandom, $urandom}));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSQ, regAddr(5), '0));

		testName = "store32 keeps upper half";
		wordSet   = $urandom | 32'h8000_0000;
		wordClear = $urandom & 32'h7FFF_FFFF;
		runRequest(makeRequest(ringMmioPkg::RING_OPM_STSQ, regAddr(9), {$urandom, $urandom}));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_STSL, regAddr(9), {$urandom, wordSet}));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSQ, regAddr(9), '0));
		testName = "load32 sign extension";
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSL, regAddr(9), '0));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_STSL, regAddr(9), {$urandom, wordClear}));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSL, regAddr(9), '0));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSQ, regAddr(9), '0));

		// second request right behind the first, while the engine is busy
		testName = "request while busy";
		first  = makeRequest(ringMmioPkg::RING_OPM_STSQ, regAddr(2), {$urandom, $urandom});
		second = makeRequest(ringMmioPkg::RING_OPM_LDSQ, regAddr(2), '0);
		seen   = responsesSeen;
		respQueue.push_back(expectedResponse(first));
		driveSlot(first, KIND_TAKE);
		driveSlot(second, KIND_PASS);
		waitForResponse(seen);
		drainIdle();
		testName = "resent request";
		runRequest(second);

		testName = "response under back-pressure";
		first = makeRequest(ringMmioPkg::RING_OPM_LDSL, regAddr(9), '0);
		seen  = responsesSeen;
		respQueue.push_back(expectedResponse(first));
		driveSlot(first, KIND_TAKE);
		repeat (BURST_CYCLES) driveSlot(randomForeign(), KIND_PASS);
		driveSlot(ringMmioPkg::RING_SLOT_IDLE, KIND_RESP_DUE);
		waitForResponse(seen);
		drainIdle();

		testName = "outside the window";
		runRequest(makeRequest(ringMmioPkg::RING_OPM_STSQ, regAddr(-1), {$urandom, $urandom}));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_STSL, regAddr(REG_COUNT), {$urandom, $urandom}));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_STSQ, 32'h0000_0100, {$urandom, $urandom}));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSQ, regAddr(-1), '0));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSL, regAddr(REG_COUNT), '0));
		runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSQ, 32'hFFFF_FFF8, '0));
		testName = "register readback";
		for (int i = 0; i < REG_COUNT; i++)
			runRequest(makeRequest(ringMmioPkg::RING_OPM_LDSQ, regAddr(i), '0));

		testName = "end of run";
		repeat (END_CYCLES) driveSlot(ringMmioPkg::RING_SLOT_IDLE, KIND_IDLE);
		if (respQueue.size() != 0)
			stopWithFailure("responses were still outstanding at the end of the run");
		else
		begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

//--- source/mmioRegisterBlock.sv
/*
 MMIO device: a bank of 64-bit registers in one address
 window, answering each access after a fixed number of
 HOLD cycles.
 */

`timescale 1ns/100ps

`include "ringMmio_cfg.svh"

module mmioRegisterBlock (
	input  logic                    clock,
	input  logic                    reset,
	input  ringMmioPkg::mmioRequest mmioReq,
	output ringMmioPkg::mmioStatus  mmioOk,
	output logic [63:0]             mmioData
);

	localparam int IDX_W  = $clog2(`RM_REG_COUNT);
	localparam int WAIT_W = $clog2(`RM_WAIT_STATES + 1);

	logic [63:0]       regs [`RM_REG_COUNT];
	logic [31:0]       offset;
	logic [IDX_W-1:0]  regIndex;
	logic              inWindow;
	logic [WAIT_W-1:0] waitCount;
	logic              doAccess;	// last HOLD cycle
	logic [63:0]       readData;

	assign offset   = mmioReq.addr - `RM_WINDOW_BASE;
	assign inWindow = (offset < 32'(`RM_REG_COUNT * 8));	// wraps below base too
	assign regIndex = offset[IDX_W+2:3];
	assign doAccess = (mmioOk == ringMmioPkg::MMIO_OK_HOLD) && (waitCount == '0);

	always_comb
	begin
		readData = '0;
		if (inWindow && mmioReq.op == ringMmioPkg::MMIO_RD_Q)
			readData = regs[regIndex];
		else if (inWindow && mmioReq.op == ringMmioPkg::MMIO_RD_L)
			readData = {{32{regs[regIndex][31]}}, regs[regIndex][31:0]};
	end

	// READY -> HOLD -> OK, back to READY once the op drops
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mmioOk    <= ringMmioPkg::MMIO_OK_READY;
			waitCount <= '0;
		end
		else if (mmioOk == ringMmioPkg::MMIO_OK_READY)
		begin
			if (mmioReq.op != ringMmioPkg::MMIO_READY)
			begin
				mmioOk    <= ringMmioPkg::MMIO_OK_HOLD;
				waitCount <= WAIT_W'(`RM_WAIT_STATES - 1);
			end
		end
		else if (mmioOk == ringMmioPkg::MMIO_OK_HOLD)
		begin
			if (doAccess)
				mmioOk <= ringMmioPkg::MMIO_OK_OK;
			else
				waitCount <= waitCount - 1'b1;
		end
		else if (mmioReq.op == ringMmioPkg::MMIO_READY)
			mmioOk <= ringMmioPkg::MMIO_OK_READY;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `RM_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (doAccess && inWindow)
		begin
			if (mmioReq.op == ringMmioPkg::MMIO_WR_Q)
				regs[regIndex] <= mmioReq.data;
			else if (mmioReq.op == ringMmioPkg::MMIO_WR_L)
				regs[regIndex][31:0] <= mmioReq.data[31:0];	// upper half kept
		end
	end

	always_ff @(posedge clock)
	begin
		if (doAccess)
			mmioData <= readData;	// zero for writes and misses
	end

endmodule

//--- source/mmioRequestEngine.sv
/*
 MMIO request engine. Captures one ring request, issues it
 on the MMIO bus through two register stages, captures the
 device result and offers the response slot to the merge.
 */

`timescale 1ns/100ps

module mmioRequestEngine (
	input  logic                    clock,
	input  logic                    reset,
	input  ringMmioPkg::ringSlot    ringIn,
	input  logic                    isMmio,
	input  ringMmioPkg::mmioOp      mmioOp,
	output logic                    takeRequest,
	output logic                    respPending,
	output ringMmioPkg::ringSlot    respSlot,
	input  logic                    respSent,
	output ringMmioPkg::mmioRequest mmioReq,
	input  ringMmioPkg::mmioStatus  mmioOk,
	input  logic [63:0]             mmioData
);

	ringMmioPkg::ringSlot    reqSlot;	// live request as taken off the ring
	ringMmioPkg::mmioOp      reqOp;
	logic                    reqLive;
	ringMmioPkg::mmioRequest issueReq;	// first issue stage
	ringMmioPkg::mmioStatus  okReg;
	logic [63:0]             dataReg;
	logic                    respDone;	// result captured
	logic                    respSentSeen;	// response already on the ring
	logic [63:0]             respData;

	assign takeRequest = isMmio && !reqLive;
	assign respPending = respDone && !respSentSeen;

	assign respSlot = '{
		seq:  reqSlot.seq,
		opm:  {reqSlot.opm[15:8], ringMmioPkg::RING_OPM_OKLD},
		addr: reqSlot.addr,
		data: respData
	};

	always_ff @(posedge clock)
	begin
		if (takeRequest)
		begin
			reqSlot <= ringIn;
			reqOp   <= mmioOp;
		end
		if (okReg == ringMmioPkg::MMIO_OK_OK && !respDone)
			respData <= dataReg;
		dataReg <= mmioData;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			okReg <= ringMmioPkg::MMIO_OK_READY;
		else
			okReg <= mmioOk;
	end

	// request lifetime
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqLive      <= 1'b0;
			respDone     <= 1'b0;
			respSentSeen <= 1'b0;
		end
		else if (respDone && respSentSeen && okReg == ringMmioPkg::MMIO_OK_READY)
		begin
			reqLive      <= 1'b0;	// free for the next request
			respDone     <= 1'b0;
			respSentSeen <= 1'b0;
		end
		else
		begin
			if (takeRequest)
				reqLive <= 1'b1;
			if (okReg == ringMmioPkg::MMIO_OK_OK && reqLive)
				respDone <= 1'b1;
			if (respSent)
				respSentSeen <= 1'b1;
		end
	end

	// two-stage issue onto the MMIO bus
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			issueReq.op <= ringMmioPkg::MMIO_READY;
			mmioReq.op  <= ringMmioPkg::MMIO_READY;
		end
		else
		begin
			if (okReg == ringMmioPkg::MMIO_OK_OK || respDone)
				issueReq.op <= ringMmioPkg::MMIO_READY;	// device answered
			else if (okReg == ringMmioPkg::MMIO_OK_READY && reqLive)
				issueReq <= '{op: reqOp, addr: reqSlot.addr, data: reqSlot.data};
			mmioReq <= issueReq;
		end
	end

endmodule

//--- source/ringMmioNode.sv
/*
 Ring MMIO node top level: slot decode, request engine,
 output slot merge and the register block device.
 */

`timescale 1ns/100ps

module ringMmioNode (
	input  logic                 clock,
	input  logic                 reset,
	input  ringMmioPkg::ringSlot ringIn,
	output ringMmioPkg::ringSlot ringOut
);

	logic                    isMmio;
	logic                    isIdle;
	ringMmioPkg::mmioOp      mmioOp;
	logic                    takeRequest;
	logic                    respPending;
	ringMmioPkg::ringSlot    respSlot;
	logic                    respSent;
	ringMmioPkg::mmioRequest mmioReq;
	ringMmioPkg::mmioStatus  mmioOk;
	logic [63:0]             mmioData;

	ringOpDecode i_ringOpDecode (
		.ringIn (ringIn),
		.isMmio (isMmio),
		.isIdle (isIdle),
		.mmioOp (mmioOp)
	);

	mmioRequestEngine i_mmioRequestEngine (
		.clock       (clock),
		.reset       (reset),
		.ringIn      (ringIn),
		.isMmio      (isMmio),
		.mmioOp      (mmioOp),
		.takeRequest (takeRequest),
		.respPending (respPending),
		.respSlot    (respSlot),
		.respSent    (respSent),
		.mmioReq     (mmioReq),
		.mmioOk      (mmioOk),
		.mmioData    (mmioData)
	);

	ringSlotMerge i_ringSlotMerge (
		.clock       (clock),
		.reset       (reset),
		.ringIn      (ringIn),
		.isIdle      (isIdle),
		.takeRequest (takeRequest),
		.respPending (respPending),
		.respSlot    (respSlot),
		.ringOut     (ringOut),
		.respSent    (respSent)
	);

	mmioRegisterBlock i_mmioRegisterBlock (
		.clock    (clock),
		.reset    (reset),
		.mmioReq  (mmioReq),
		.mmioOk   (mmioOk),
		.mmioData (mmioData)
	);

endmodule

//--- source/ringMmioPkg.sv
/*
 Shared types of the ring MMIO node: ring slot layout,
 ring opcodes, MMIO bus opcodes, MMIO status codes
 and the MMIO bus request.
 */

package ringMmioPkg;

	// ring opcodes, low byte of opm
	localparam logic [7:0] RING_OPM_IDLE = 8'h00;
	localparam logic [7:0] RING_OPM_LDSL = 8'h92;	// 32-bit load, sign-extended
	localparam logic [7:0] RING_OPM_LDSQ = 8'h93;	// 64-bit load
	localparam logic [7:0] RING_OPM_STSL = 8'hA2;	// 32-bit store
	localparam logic [7:0] RING_OPM_STSQ = 8'hA3;	// 64-bit store
	localparam logic [7:0] RING_OPM_OKLD = 8'h60;	// response

	// one ring slot, 128 bits
	typedef struct packed {
		logic [15:0] seq;	// requester's sequence tag
		logic [15:0] opm;	// flags in upper byte, operation in lower
		logic [31:0] addr;
		logic [63:0] data;
	} ringSlot;

	// an empty slot is all zero
	localparam ringSlot RING_SLOT_IDLE = '0;

	typedef enum logic [4:0] {
		MMIO_READY = 5'h00,
		MMIO_RD_Q  = 5'h03,
		MMIO_RD_L  = 5'h02,
		MMIO_WR_Q  = 5'h0B,
		MMIO_WR_L  = 5'h0A
	} mmioOp;

	typedef enum logic [1:0] {
		MMIO_OK_READY = 2'b00,
		MMIO_OK_OK    = 2'b01,
		MMIO_OK_HOLD  = 2'b10
	} mmioStatus;

	// request on the MMIO bus, 101 bits
	typedef struct packed {
		mmioOp       op;
		logic [31:0] addr;
		logic [63:0] data;
	} mmioRequest;

endpackage

//--- source/ringMmio_cfg.svh
/*
 Build-time parameters of the ring MMIO node:
 register window base address, register count
 and device latency in cycles.
 */

`ifndef RING_MMIO_CFG_SVH
`define RING_MMIO_CFG_SVH

// base of the register window on the MMIO bus
`define RM_WINDOW_BASE 32'hF000_C000

// number of 64-bit registers, power of two
`define RM_REG_COUNT 16

// cycles of HOLD before the device answers OK, at least 1
`define RM_WAIT_STATES 3

`endif

//--- source/ringOpDecode.sv
/*
 Ring slot classifier. Flags idle slots and MMIO requests
 and maps the ring operation to its MMIO bus operation.
 */

`timescale 1ns/100ps

module ringOpDecode (
	input  ringMmioPkg::ringSlot ringIn,
	output logic                 isMmio,
	output logic                 isIdle,
	output ringMmioPkg::mmioOp   mmioOp
);

	logic [7:0] opCode;

	assign opCode = ringIn.opm[7:0];	// flags byte ignored here

	assign isIdle = (opCode == ringMmioPkg::RING_OPM_IDLE);

	// foreign traffic leaves both flags low
	always_comb
	begin
		isMmio = 1'b1;
		mmioOp = ringMmioPkg::MMIO_READY;
		case (opCode)
			ringMmioPkg::RING_OPM_LDSQ:
			begin
				mmioOp = ringMmioPkg::MMIO_RD_Q;
			end
			ringMmioPkg::RING_OPM_LDSL:
			begin
				mmioOp = ringMmioPkg::MMIO_RD_L;	// sign-extended by device
			end
			ringMmioPkg::RING_OPM_STSQ:
			begin
				mmioOp = ringMmioPkg::MMIO_WR_Q;
			end
			ringMmioPkg::RING_OPM_STSL:
			begin
				mmioOp = ringMmioPkg::MMIO_WR_L;
			end
			default:
			begin
				isMmio = 1'b0;
			end
		endcase
	end

endmodule

//--- source/ringSlotMerge.sv
/*
 Output slot register of the node. Passes ring traffic
 through, replaces a consumed request with an idle slot
 and drops the pending response into an idle slot.
 */

`timescale 1ns/100ps

module ringSlotMerge (
	input  logic                 clock,
	input  logic                 reset,
	input  ringMmioPkg::ringSlot ringIn,
	input  logic                 isIdle,
	input  logic                 takeRequest,
	input  logic                 respPending,
	input  ringMmioPkg::ringSlot respSlot,
	output ringMmioPkg::ringSlot ringOut,
	output logic                 respSent
);

	ringMmioPkg::ringSlot nextSlot;

	// response only rides on an empty slot
	assign respSent = isIdle && respPending;

	/*
	 A consumed request and an idle slot never arrive in the
	 same cycle, so the order of the first two cases only
	 matters for readability.
	 */
	always_comb
	begin
		if (takeRequest)
			nextSlot = ringMmioPkg::RING_SLOT_IDLE;	// request leaves the ring
		else if (respSent)
			nextSlot = respSlot;
		else
			nextSlot = ringIn;	// pass through unchanged
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			ringOut <= ringMmioPkg::RING_SLOT_IDLE;
		else
			ringOut <= nextSlot;
	end

endmodule
